// ==== files.f ====
hw/gpu_pkg.sv
hw/mem_channel_if.sv
hw/lsu.sv
hw/warp_controller.sv
hw/thread_regfile.sv
hw/mem_arbiter.sv
hw/gpu_mem_core.sv
tb/tb_gpu_mem_core.sv

// ==== hw/gpu_mem_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module gpu_mem_core #(
    parameter int THREADS = 4
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           instr_start,
    input  wire gpu_pkg::instr_t          instr,
    input  wire [3:0]                     thread_count,
    input  wire                           host_write,
    input  wire [2:0]                     host_thread,
    input  wire gpu_pkg::reg_index_t      host_index,
    input  wire gpu_pkg::data_t           host_data,
    input  wire [2:0]                     host_read_thread,
    input  wire gpu_pkg::reg_index_t      host_read_index,
    output gpu_pkg::data_t                host_read_data,
    output logic                          busy,
    output logic                          done,
    output logic                          mem_read_valid,
    output gpu_pkg::data_memory_address_t mem_read_address,
    input  wire                           mem_read_ready,
    input  wire gpu_pkg::data_t           mem_read_data,
    output logic                          mem_write_valid,
    output gpu_pkg::data_memory_address_t mem_write_address,
    output gpu_pkg::data_t                mem_write_data,
    input  wire                           mem_write_ready
);
    import gpu_pkg::*;

    warp_state_t        warp_state;
    logic [THREADS-1:0] thread_enable;
    logic               mem_read_enable;
    logic               mem_write_enable;
    reg_index_t         reg_a;
    reg_index_t         reg_b;
    reg_index_t         reg_d;
    data_t              imm;
    lsu_state_t         lsu_state [THREADS];
    data_t              lsu_out [THREADS];
    data_t              rs1 [THREADS];
    data_t              rs2 [THREADS];
    data_t              readback [THREADS];

    mem_channel_if chan [THREADS] ();

    warp_controller #(.THREADS(THREADS)) u_warp_controller (
        .clk, .reset, .instr_start, .instr, .thread_count, .lsu_state,
        .warp_state, .thread_enable, .mem_read_enable, .mem_write_enable,
        .reg_a, .reg_b, .reg_d, .imm, .busy, .done
    );

    for (genvar i = 0; i < THREADS; i++) begin : g_thread
        thread_regfile u_regfile (
            .clk, .reset,
            .thread_id       (3'(i)),
            .host_write      (host_write && host_thread == 3'(i)),
            .host_index, .host_data, .host_read_index,
            .read_a          (reg_a),
            .read_b          (reg_b),
            .writeback       (thread_enable[i] && mem_read_enable
                              && warp_state == WARP_UPDATE),
            .write_index     (reg_d),
            .write_data      (lsu_out[i]),
            .host_read_data  (readback[i]),
            .data_a          (rs1[i]),
            .data_b          (rs2[i])
        );

        lsu u_lsu (
            .clk, .reset,
            .enable                   (thread_enable[i]),
            .warp_state,
            .decoded_mem_read_enable  (mem_read_enable),
            .decoded_mem_write_enable (mem_write_enable),
            .rs1                      (rs1[i]),
            .rs2                      (rs2[i]),
            .imm,
            .mem                      (chan[i]),
            .lsu_state                (lsu_state[i]),
            .lsu_out                  (lsu_out[i])
        );
    end

    mem_arbiter #(.THREADS(THREADS)) u_mem_arbiter (
        .clk, .reset, .chan,
        .mem_read_valid, .mem_read_address, .mem_read_ready, .mem_read_data,
        .mem_write_valid, .mem_write_address, .mem_write_data, .mem_write_ready
    );

    // Threads outside the built range read back as zero
    always_comb begin
        host_read_data = '0;
        for (int i = 0; i < THREADS; i++) begin
            if (host_read_thread == 3'(i)) begin
                host_read_data = readback[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

    typedef logic [7:0] data_t;
    typedef logic [7:0] data_memory_address_t;
    typedef logic [2:0] reg_index_t;

    // Shared warp phase, broadcast to every lsu
    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_REQUEST,
        WARP_WAIT,
        WARP_EXECUTE,
        WARP_UPDATE
    } warp_state_t;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQUESTING,
        LSU_WAITING,
        LSU_DONE
    } lsu_state_t;

    localparam logic [3:0] OP_LDR = 4'b0111;
    localparam logic [3:0] OP_STR = 4'b1000;

    // Layout is opcode, register, base register, then a 6-bit zero-extended offset
    typedef struct packed {
        logic [3:0] opcode;
        reg_index_t rd;
        reg_index_t rs;
        logic [5:0] imm;
    } ldr_view_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_index_t rt;
        reg_index_t rs;
        logic [5:0] imm;
    } str_view_t;

    typedef union packed {
        ldr_view_t ldr;
        str_view_t str;
    } instr_t;

endpackage

`default_nettype wire

// ==== hw/lsu.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu (
    input  wire                     clk,
    input  wire                     reset,
    // Low when this thread is beyond the active thread count
    input  wire                     enable,
    input  wire gpu_pkg::warp_state_t warp_state,
    input  wire                     decoded_mem_read_enable,
    input  wire                     decoded_mem_write_enable,
    input  wire gpu_pkg::data_t     rs1,
    input  wire gpu_pkg::data_t     rs2,
    input  wire gpu_pkg::data_t     imm,
    mem_channel_if.lsu              mem,
    output gpu_pkg::lsu_state_t     lsu_state,
    output gpu_pkg::data_t          lsu_out
);
    import gpu_pkg::*;

    data_memory_address_t offset_address;
    logic                 active;
    logic                 read_accept;
    logic                 write_accept;

    assign offset_address = rs1 + imm;
    assign active = enable && (decoded_mem_read_enable || decoded_mem_write_enable);
    assign read_accept = mem.read_valid && mem.read_ready;
    assign write_accept = mem.write_valid && mem.write_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_state <= LSU_IDLE;
            mem.read_valid <= 1'b0;
            mem.write_valid <= 1'b0;
        end else if (active) begin
            case (lsu_state)
                LSU_IDLE: begin
                    // Start only once the warp reaches its request phase
                    if (warp_state == WARP_REQUEST) begin
                        lsu_state <= LSU_REQUESTING;
                    end
                end
                LSU_REQUESTING: begin
                    // Load wins if both flags were ever set together
                    mem.read_valid <= decoded_mem_read_enable;
                    mem.write_valid <= decoded_mem_write_enable && !decoded_mem_read_enable;
                    lsu_state <= LSU_WAITING;
                end
                LSU_WAITING: begin
                    if (read_accept) begin
                        mem.read_valid <= 1'b0;
                        lsu_state <= LSU_DONE;
                    end
                    if (write_accept) begin
                        mem.write_valid <= 1'b0;
                        lsu_state <= LSU_DONE;
                    end
                end
                LSU_DONE: begin
                    // Hold done until the warp has written back
                    if (warp_state == WARP_UPDATE) begin
                        lsu_state <= LSU_IDLE;
                    end
                end
                default: begin
                    lsu_state <= LSU_IDLE;
                end
            endcase
        end
    end

    // Request payload is captured with the valid and held until ready
    always_ff @(posedge clk) begin
        if (active && lsu_state == LSU_REQUESTING) begin
            mem.read_address <= offset_address;
            mem.write_address <= offset_address;
            mem.write_data <= rs2;
        end
    end

    // Loaded value stays here until the next load
    always_ff @(posedge clk) begin
        if (active && lsu_state == LSU_WAITING && read_accept) begin
            lsu_out <= mem.read_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int THREADS = 4
) (
    input  wire                               clk,
    input  wire                               reset,
    mem_channel_if.ctrl                       chan [THREADS],
    output logic                              mem_read_valid,
    output gpu_pkg::data_memory_address_t     mem_read_address,
    input  wire                               mem_read_ready,
    input  wire gpu_pkg::data_t               mem_read_data,
    output logic                              mem_write_valid,
    output gpu_pkg::data_memory_address_t     mem_write_address,
    output gpu_pkg::data_t                    mem_write_data,
    input  wire                               mem_write_ready
);
    import gpu_pkg::*;

    localparam int IW = (THREADS > 1) ? $clog2(THREADS) : 1;
    localparam logic [1:0] ARB_IDLE = 2'd0;
    localparam logic [1:0] ARB_BUSY = 2'd1;
    localparam logic [1:0] ARB_RELEASE = 2'd2;

    logic [1:0]           state;
    logic [IW-1:0]        grant;
    logic [IW-1:0]        pick;
    logic                 found;
    logic                 rd_valid [THREADS];
    logic                 wr_valid [THREADS];
    data_memory_address_t rd_addr [THREADS];
    data_memory_address_t wr_addr [THREADS];
    data_t                wr_data [THREADS];
    logic                 accept;

    assign accept = (state == ARB_BUSY) && ((mem_read_valid && mem_read_ready)
                    || (mem_write_valid && mem_write_ready));

    for (genvar i = 0; i < THREADS; i++) begin : g_chan
        assign rd_valid[i] = chan[i].read_valid;
        assign wr_valid[i] = chan[i].write_valid;
        assign rd_addr[i] = chan[i].read_address;
        assign wr_addr[i] = chan[i].write_address;
        assign wr_data[i] = chan[i].write_data;
        // Ready reaches the granted lsu in the same cycle as the external ready
        assign chan[i].read_ready = accept && mem_read_valid && (grant == IW'(i));
        assign chan[i].write_ready = accept && mem_write_valid && (grant == IW'(i));
        assign chan[i].read_data = mem_read_data;
    end

    // Round-robin search starting after the last channel served
    always_comb begin
        int idx;
        found = 1'b0;
        pick = '0;
        for (int k = 1; k <= THREADS; k++) begin
            idx = (int'(grant) + k) % THREADS;
            if (!found && (rd_valid[idx] || wr_valid[idx])) begin
                found = 1'b1;
                pick = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ARB_IDLE;
            grant <= IW'(THREADS - 1);
            mem_read_valid <= 1'b0;
            mem_write_valid <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant <= pick;
                        mem_read_valid <= rd_valid[pick];
                        mem_write_valid <= wr_valid[pick] && !rd_valid[pick];
                        state <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (accept) begin
                        mem_read_valid <= 1'b0;
                        mem_write_valid <= 1'b0;
                        state <= ARB_RELEASE;
                    end
                end
                // Lets the served lsu drop its valid before the next search
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && found) begin
            mem_read_address <= rd_addr[pick];
            mem_write_address <= wr_addr[pick];
            mem_write_data <= wr_data[pick];
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_channel_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface mem_channel_if;
    import gpu_pkg::*;

    logic                 read_valid;
    data_memory_address_t read_address;
    logic                 read_ready;
    data_t                read_data;
    logic                 write_valid;
    data_memory_address_t write_address;
    data_t                write_data;
    logic                 write_ready;

    modport lsu (
        output read_valid, read_address, write_valid, write_address, write_data,
        input  read_ready, read_data, write_ready
    );

    modport ctrl (
        input  read_valid, read_address, write_valid, write_address, write_data,
        output read_ready, read_data, write_ready
    );
endinterface

`default_nettype wire

// ==== hw/thread_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

module thread_regfile (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [2:0]                thread_id,
    input  wire                      host_write,
    input  wire gpu_pkg::reg_index_t host_index,
    input  wire gpu_pkg::data_t      host_data,
    input  wire gpu_pkg::reg_index_t host_read_index,
    input  wire gpu_pkg::reg_index_t read_a,
    input  wire gpu_pkg::reg_index_t read_b,
    input  wire                      writeback,
    input  wire gpu_pkg::reg_index_t write_index,
    input  wire gpu_pkg::data_t      write_data,
    output gpu_pkg::data_t           host_read_data,
    output gpu_pkg::data_t           data_a,
    output gpu_pkg::data_t           data_b
);
    import gpu_pkg::*;

    data_t regs [7];

    // r7 is hardwired to the thread index
    function automatic data_t read_reg(input reg_index_t idx);
        if (idx == 3'd7) begin
            return {5'b00000, thread_id};
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback) begin
            if (write_index != 3'd7) begin
                regs[write_index] <= write_data;
            end
        end else if (host_write && host_index != 3'd7) begin
            regs[host_index] <= host_data;
        end
    end

    always_comb begin
        data_a = read_reg(read_a);
        data_b = read_reg(read_b);
        host_read_data = read_reg(host_read_index);
    end

endmodule

`default_nettype wire

// ==== hw/warp_controller.sv ====
`default_nettype none
`timescale 1ns/1ps

module warp_controller #(
    parameter int THREADS = 4
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       instr_start,
    input  wire gpu_pkg::instr_t      instr,
    input  wire [3:0]                 thread_count,
    input  wire gpu_pkg::lsu_state_t  lsu_state [THREADS],
    output gpu_pkg::warp_state_t      warp_state,
    output logic [THREADS-1:0]        thread_enable,
    output logic                      mem_read_enable,
    output logic                      mem_write_enable,
    output gpu_pkg::reg_index_t       reg_a,
    output gpu_pkg::reg_index_t       reg_b,
    output gpu_pkg::reg_index_t       reg_d,
    output gpu_pkg::data_t            imm,
    output logic                      busy,
    output logic                      done
);
    import gpu_pkg::*;

    instr_t instr_q;
    logic   is_store;
    logic   all_done;

    assign is_store = (instr_q.str.opcode == OP_STR);
    assign busy = (warp_state != WARP_IDLE);

    // A no-operation leaves every lsu idle, so nothing is waited on
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < THREADS; i++) begin
            if (thread_enable[i] && (mem_read_enable || mem_write_enable)
                    && lsu_state[i] != LSU_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_state <= WARP_IDLE;
            thread_enable <= '0;
            mem_read_enable <= 1'b0;
            mem_write_enable <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (warp_state)
                WARP_IDLE: begin
                    if (instr_start) begin
                        warp_state <= WARP_FETCH;
                    end
                end
                WARP_FETCH: warp_state <= WARP_DECODE;
                WARP_DECODE: begin
                    mem_read_enable <= (instr_q.ldr.opcode == OP_LDR);
                    mem_write_enable <= is_store;
                    for (int i = 0; i < THREADS; i++) begin
                        thread_enable[i] <= (i < int'(thread_count));
                    end
                    warp_state <= WARP_REQUEST;
                end
                WARP_REQUEST: warp_state <= WARP_WAIT;
                WARP_WAIT: begin
                    if (all_done) begin
                        warp_state <= WARP_EXECUTE;
                    end
                end
                WARP_EXECUTE: warp_state <= WARP_UPDATE;
                WARP_UPDATE: begin
                    warp_state <= WARP_IDLE;
                    done <= 1'b1;
                end
                default: warp_state <= WARP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (warp_state == WARP_FETCH) begin
            instr_q <= instr;
        end
        if (warp_state == WARP_DECODE) begin
            // Base and offset sit at the same position in both views
            reg_a <= instr_q.ldr.rs;
            reg_b <= instr_q.str.rt;
            reg_d <= instr_q.ldr.rd;
            imm <= {2'b00, instr_q.ldr.imm};
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_gpu_mem_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_gpu_mem_core;
    import gpu_pkg::*;

    localparam int THREADS = 4;
    localparam int NUM_INSTR = 200;
    localparam int DONE_TIMEOUT = 500;
    localparam int SEED = 34;

    logic                 clk;
    logic                 reset;
    logic                 instr_start;
    instr_t               instr;
    logic [3:0]           thread_count;
    logic                 host_write;
    logic [2:0]           host_thread;
    reg_index_t           host_index;
    data_t                host_data;
    logic [2:0]           host_read_thread;
    reg_index_t           host_read_index;
    data_t                host_read_data;
    logic                 busy;
    logic                 done;
    logic                 mem_read_valid;
    data_memory_address_t mem_read_address;
    logic                 mem_read_ready;
    data_t                mem_read_data;
    logic                 mem_write_valid;
    data_memory_address_t mem_write_address;
    data_t                mem_write_data;
    logic                 mem_write_ready;

    // Memory behind the external port, and the reference copies
    data_t mem_array [256];
    data_t ref_mem [256];
    data_t ref_regs [THREADS][8];

    // Traffic expected from the instruction in flight
    logic                 exp_read;
    logic                 exp_write;
    int                   exp_active;
    data_memory_address_t exp_addr [THREADS];
    data_t                exp_data [THREADS];
    logic                 served [THREADS];
    int                   req_count;

    int   error_count;
    int   check_count;
    logic timed_out;

    gpu_mem_core #(.THREADS(THREADS)) u_gpu_mem_core (
        .clk, .reset, .instr_start, .instr, .thread_count,
        .host_write, .host_thread, .host_index, .host_data,
        .host_read_thread, .host_read_index, .host_read_data,
        .busy, .done,
        .mem_read_valid, .mem_read_address, .mem_read_ready, .mem_read_data,
        .mem_write_valid, .mem_write_address, .mem_write_data, .mem_write_ready
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Pairs a new external request with one unserved active thread
    task automatic match_request(input logic is_read, input data_memory_address_t addr,
                                 input data_t wdata);
        logic found;
        found = 1'b0;
        req_count++;
        for (int t = 0; t < exp_active; t++) begin
            if (!found && !served[t] && exp_addr[t] == addr
                    && (is_read ? exp_read : (exp_write && exp_data[t] == wdata))) begin
                found = 1'b1;
                served[t] = 1'b1;
            end
        end
        if (!found) begin
            error_count++;
            $display("Error at %0t: unexpected %s request to address %h", $time,
                     is_read ? "read" : "write", addr);
        end
    endtask

    // Memory model with a random ready delay of 0 to 5 cycles
    initial begin : memory_model
        logic                 serving;
        logic                 is_read;
        data_memory_address_t addr;
        data_t                wdata;
        data_memory_address_t cur_addr;
        int                   delay;
        serving = 1'b0;
        is_read = 1'b0;
        addr = '0;
        wdata = '0;
        delay = 0;
        mem_read_ready = 1'b0;
        mem_write_ready = 1'b0;
        mem_read_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_read_ready || mem_write_ready) begin
                mem_read_ready = 1'b0;
                mem_write_ready = 1'b0;
                if (mem_read_valid || mem_write_valid) begin
                    error_count++;
                    $display("Error at %0t: external valid still high after ready", $time);
                end
            end else if (mem_read_valid || mem_write_valid) begin
                if (!serving) begin
                    if (mem_read_valid && mem_write_valid) begin
                        error_count++;
                        $display("Error at %0t: read and write valid high together", $time);
                    end
                    serving = 1'b1;
                    is_read = mem_read_valid;
                    addr = is_read ? mem_read_address : mem_write_address;
                    wdata = mem_write_data;
                    delay = $urandom % 6;
                    match_request(is_read, addr, wdata);
                end else begin
                    // Request must stay unchanged until ready
                    cur_addr = is_read ? mem_read_address : mem_write_address;
                    check_count++;
                    if (mem_read_valid !== is_read) begin
                        error_count++;
                        $display("Mismatch at %0t: mem_read_valid expected %b got %b",
                                 $time, is_read, mem_read_valid);
                    end
                    if (cur_addr !== addr) begin
                        error_count++;
                        $display("Mismatch at %0t: %s expected %h got %h", $time,
                                 is_read ? "mem_read_address" : "mem_write_address",
                                 addr, cur_addr);
                    end
                end
                if (delay == 0) begin
                    serving = 1'b0;
                    if (is_read) begin
                        mem_read_data = mem_array[addr];
                        mem_read_ready = 1'b1;
                    end else begin
                        mem_array[addr] = mem_write_data;
                        mem_write_ready = 1'b1;
                    end
                end else begin
                    delay--;
                end
            end else if (serving) begin
                error_count++;
                $display("Error at %0t: request valid dropped before ready", $time);
                serving = 1'b0;
                delay = 0;
            end
        end
    end

    task automatic load_registers();
        data_t value;
        for (int t = 0; t < THREADS; t++) begin
            for (int r = 0; r < 8; r++) begin
                // Small values make threads collide on addresses now and then
                value = ($urandom % 2) ? data_t'($urandom % 4) : data_t'($urandom);
                @(posedge clk);
                #1;
                host_write = 1'b1;
                host_thread = 3'(t);
                host_index = reg_index_t'(r);
                host_data = value;
                if (r != 7) begin
                    ref_regs[t][r] = value;
                end
            end
        end
        @(posedge clk);
        #1;
        host_write = 1'b0;
    endtask

    task automatic read_back_registers();
        data_t expected;
        for (int t = 0; t < THREADS; t++) begin
            for (int r = 0; r < 8; r++) begin
                @(posedge clk);
                #1;
                host_read_thread = 3'(t);
                host_read_index = reg_index_t'(r);
                @(negedge clk);
                expected = (r == 7) ? data_t'(t) : ref_regs[t][r];
                check_count++;
                if (host_read_data !== expected) begin
                    error_count++;
                    $display("Mismatch at %0t: host_read_data thread %0d r%0d expected %h got %h",
                             $time, t, r, expected, host_read_data);
                end
            end
        end
    endtask

    // Stored words may come from any thread that wrote the address
    task automatic check_memory();
        logic  written;
        logic  ok;
        data_t cand;
        for (int a = 0; a < 256; a++) begin
            written = 1'b0;
            ok = 1'b0;
            cand = ref_mem[a];
            for (int t = 0; t < exp_active; t++) begin
                if (exp_write && exp_addr[t] == data_memory_address_t'(a)) begin
                    written = 1'b1;
                    cand = exp_data[t];
                    if (mem_array[a] == exp_data[t]) begin
                        ok = 1'b1;
                    end
                end
            end
            check_count++;
            if ((written && !ok) || (!written && mem_array[a] !== ref_mem[a])) begin
                error_count++;
                $display("Mismatch at %0t: mem_array[%h] expected %h got %h",
                         $time, a[7:0], cand, mem_array[a]);
            end
            ref_mem[a] = mem_array[a];
        end
    endtask

    task automatic run_instruction();
        logic [3:0] opcode;
        reg_index_t f1;
        reg_index_t f2;
        logic [5:0] imm6;
        int         tc;
        int         pick;
        int         cycles;
        data_t      base;
        pick = $urandom % 5;
        opcode = 4'($urandom % 16);
        if (opcode == OP_LDR || opcode == OP_STR) begin
            opcode = 4'h0;
        end
        if (pick < 2) begin
            opcode = OP_LDR;
        end else if (pick < 4) begin
            opcode = OP_STR;
        end
        f1 = reg_index_t'($urandom);
        f2 = reg_index_t'($urandom);
        imm6 = 6'($urandom);
        tc = $urandom % (THREADS + 2);
        exp_read = (opcode == OP_LDR);
        exp_write = (opcode == OP_STR);
        exp_active = (exp_read || exp_write) ? ((tc < THREADS) ? tc : THREADS) : 0;
        for (int t = 0; t < THREADS; t++) begin
            served[t] = 1'b0;
            base = (f2 == 3'd7) ? data_t'(t) : ref_regs[t][f2];
            exp_addr[t] = base + {2'b00, imm6};
            exp_data[t] = (f1 == 3'd7) ? data_t'(t) : ref_regs[t][f1];
        end
        req_count = 0;

        @(posedge clk);
        #1;
        if (busy) begin
            error_count++;
            $display("Error at %0t: busy high before the instruction started", $time);
        end
        instr = {opcode, f1, f2, imm6};
        thread_count = 4'(tc);
        instr_start = 1'b1;
        @(posedge clk);
        #1;
        instr_start = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            if (!busy) begin
                error_count++;
                $display("Error at %0t: busy low while the instruction runs", $time);
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            error_count++;
            timed_out = 1'b1;
            $display("Error at %0t: no done within %0d cycles", $time, DONE_TIMEOUT);
            return;
        end

        check_count++;
        if (req_count != exp_active) begin
            error_count++;
            $display("Mismatch at %0t: request count expected %0d got %0d",
                     $time, exp_active, req_count);
        end
        check_memory();
        // Loads land in rd, which stays fixed when rd is r7
        if (exp_read && f1 != 3'd7) begin
            for (int t = 0; t < exp_active; t++) begin
                ref_regs[t][f1] = ref_mem[exp_addr[t]];
            end
        end
    endtask

    initial begin : main
        error_count = 0;
        check_count = 0;
        timed_out = 1'b0;
        void'($urandom(SEED));
        reset = 1'b1;
        instr_start = 1'b0;
        instr = '0;
        thread_count = '0;
        host_write = 1'b0;
        host_thread = '0;
        host_index = '0;
        host_data = '0;
        host_read_thread = '0;
        host_read_index = '0;
        exp_read = 1'b0;
        exp_write = 1'b0;
        exp_active = 0;
        req_count = 0;
        for (int a = 0; a < 256; a++) begin
            mem_array[a] = data_t'($urandom);
            ref_mem[a] = mem_array[a];
        end
        for (int t = 0; t < THREADS; t++) begin
            for (int r = 0; r < 8; r++) begin
                ref_regs[t][r] = '0;
            end
        end

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        read_back_registers();
        load_registers();
        read_back_registers();

        for (int n = 0; n < NUM_INSTR && !timed_out; n++) begin
            if (n % 25 == 24) begin
                load_registers();
            end
            run_instruction();
            if (!timed_out) begin
                read_back_registers();
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
